// ==== logic/bus_arbiter.sv ====
module bus_arbiter (
  input  logic          clk,
  input  logic          reset,
  input  logic          fetch_valid,
  input  rv_pkg::addr_t fetch_addr,
  output logic          fetch_ready,
  output logic          fetch_rvalid,
  output rv_pkg::xlen_t fetch_rdata,
  input  logic          lsu_valid,
  input  logic          lsu_write,
  input  rv_pkg::addr_t lsu_addr,
  input  rv_pkg::xlen_t lsu_wdata,
  output logic          lsu_ready,
  output logic          lsu_rvalid,
  output rv_pkg::xlen_t lsu_rdata,
  output logic          mem_valid,
  output logic          mem_write,
  output rv_pkg::addr_t mem_addr,
  output rv_pkg::xlen_t mem_wdata,
  input  logic          mem_ready,
  input  logic          mem_rvalid,
  input  rv_pkg::xlen_t mem_rdata
);

  logic read_pending;
  logic owner_lsu;

  // Load/store unit has priority
  assign mem_valid   = lsu_valid || fetch_valid;
  assign mem_write   = lsu_valid && lsu_write;
  assign mem_addr    = lsu_valid ? lsu_addr : fetch_addr;
  assign mem_wdata   = lsu_wdata;
  assign lsu_ready   = lsu_valid && mem_ready;
  assign fetch_ready = !lsu_valid && mem_ready;

  // Response goes back to whoever issued the read
  assign lsu_rvalid   = mem_rvalid && read_pending && owner_lsu;
  assign fetch_rvalid = mem_rvalid && read_pending && !owner_lsu;
  assign lsu_rdata    = mem_rdata;
  assign fetch_rdata  = mem_rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      read_pending <= 1'b0;
      owner_lsu    <= 1'b0;
    end else begin
      if (mem_rvalid) begin
        read_pending <= 1'b0;
      end
      if (mem_valid && mem_ready && !mem_write) begin
        read_pending <= 1'b1;
        owner_lsu    <= lsu_valid;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) mem_rvalid |-> read_pending);

endmodule

// ==== logic/execute_unit.sv ====
module execute_unit (
  input  rv_pkg::op_t   op,
  input  rv_pkg::addr_t pc,
  input  rv_pkg::xlen_t rs1_data,
  input  rv_pkg::xlen_t rs2_data,
  input  rv_pkg::xlen_t imm,
  output rv_pkg::xlen_t alu_result,
  output logic          branch_taken,
  output rv_pkg::addr_t next_target,
  output rv_pkg::addr_t mem_addr_calc
);
  import rv_pkg::*;

  always_comb begin
    case (op)
      op_add:  alu_result = rs1_data + rs2_data;
      op_sub:  alu_result = rs1_data - rs2_data;
      // Immediate already shifted by the decoder
      op_lui:  alu_result = imm;
      default: alu_result = rs1_data + imm;
    endcase
  end

  assign branch_taken = (op == op_beq) && (rs1_data == rs2_data);

  // Same pc-relative form serves BEQ and JAL
  assign next_target = pc + imm;

  assign mem_addr_calc = rs1_data + imm;

endmodule

// ==== logic/instruction_decoder.sv ====
module instruction_decoder (
  input  rv_pkg::inst_t    inst,
  output rv_pkg::op_t      op,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::xlen_t    imm
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  // Sign-extended immediates for each format
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    op = op_illegal;
    case (opcode)
      OPC_OP_IMM: if (funct3 == F3_ADD_SUB) op = op_addi;
      OPC_OP: begin
        if (funct3 == F3_ADD_SUB && funct7 == F7_ADD) op = op_add;
        if (funct3 == F3_ADD_SUB && funct7 == F7_SUB) op = op_sub;
      end
      OPC_LUI:    op = op_lui;
      OPC_LOAD:   if (funct3 == F3_DOUBLE) op = op_ld;
      OPC_STORE:  if (funct3 == F3_DOUBLE) op = op_sd;
      OPC_BRANCH: if (funct3 == F3_BEQ) op = op_beq;
      OPC_JAL:    op = op_jal;
      default:    op = op_illegal;
    endcase
  end

  always_comb begin
    case (op)
      op_sd:   imm = imm_s;
      op_beq:  imm = imm_b;
      op_lui:  imm = imm_u;
      op_jal:  imm = imm_j;
      default: imm = imm_i;
    endcase
  end

endmodule

// ==== logic/instruction_fetcher.sv ====
module instruction_fetcher (
  input  logic          clk,
  input  logic          reset,
  input  logic          fetch_start,
  input  rv_pkg::addr_t pc,
  input  logic          fetch_ready,
  input  logic          fetch_rvalid,
  input  rv_pkg::xlen_t fetch_rdata,
  output logic          fetch_valid,
  output rv_pkg::addr_t fetch_addr,
  output logic          fetch_done,
  output rv_pkg::inst_t fetch_inst
);

  logic waiting;
  logic sel_hi;

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_valid <= 1'b0;
      waiting     <= 1'b0;
      fetch_done  <= 1'b0;
    end else begin
      fetch_done <= 1'b0;
      if (fetch_start) begin
        // Bus works on doublewords
        fetch_valid <= 1'b1;
        fetch_addr  <= {pc[63:3], 3'b000};
        sel_hi      <= pc[2];
      end else if (fetch_valid && fetch_ready) begin
        fetch_valid <= 1'b0;
        waiting     <= 1'b1;
      end
      if (waiting && fetch_rvalid) begin
        waiting    <= 1'b0;
        fetch_done <= 1'b1;
        fetch_inst <= sel_hi ? fetch_rdata[63:32] : fetch_rdata[31:0];
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_addr));

endmodule

// ==== logic/load_store_unit.sv ====
module load_store_unit (
  input  logic          clk,
  input  logic          reset,
  input  logic          mem_start,
  input  rv_pkg::op_t   op,
  input  rv_pkg::addr_t mem_addr_calc,
  input  rv_pkg::xlen_t rs2_data,
  input  logic          lsu_ready,
  input  logic          lsu_rvalid,
  input  rv_pkg::xlen_t lsu_rdata,
  output logic          lsu_valid,
  output logic          lsu_write,
  output rv_pkg::addr_t lsu_addr,
  output rv_pkg::xlen_t lsu_wdata,
  output logic          mem_done,
  output rv_pkg::xlen_t load_data
);
  import rv_pkg::*;

  logic waiting;

  always_ff @(posedge clk) begin
    if (reset) begin
      lsu_valid <= 1'b0;
      waiting   <= 1'b0;
      mem_done  <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      if (mem_start) begin
        lsu_valid <= 1'b1;
        lsu_write <= (op == op_sd);
        lsu_addr  <= mem_addr_calc;
        lsu_wdata <= rs2_data;
      end else if (lsu_valid && lsu_ready) begin
        lsu_valid <= 1'b0;
        // Stores finish at acceptance, loads wait for data
        if (lsu_write) begin
          mem_done <= 1'b1;
        end else begin
          waiting <= 1'b1;
        end
      end
      if (waiting && lsu_rvalid) begin
        waiting   <= 1'b0;
        mem_done  <= 1'b1;
        load_data <= lsu_rdata;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    lsu_valid && !lsu_ready |=> lsu_valid && $stable(lsu_write)
      && $stable(lsu_addr) && $stable(lsu_wdata));

endmodule

// ==== logic/register_file.sv ====
module register_file (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::xlen_t    stackptr,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  logic             reg_we,
  input  rv_pkg::reg_idx_t reg_waddr,
  input  rv_pkg::xlen_t    reg_wdata,
  output rv_pkg::xlen_t    rs1_data,
  output rv_pkg::xlen_t    rs2_data
);
  import rv_pkg::*;

  xlen_t regs [32];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= (i == 2) ? stackptr : '0;
      end
    end else if (reg_we && reg_waddr != 5'd0) begin
      // x0 stays zero
      regs[reg_waddr] <= reg_wdata;
    end
  end

endmodule

// ==== logic/rv_core.sv ====
module rv_core (
  input  logic          clk,
  input  logic          reset,
  input  rv_pkg::addr_t entry,
  input  rv_pkg::xlen_t stackptr,
  input  logic          mem_ready,
  input  logic          mem_rvalid,
  input  rv_pkg::xlen_t mem_rdata,
  output logic          mem_valid,
  output logic          mem_write,
  output rv_pkg::addr_t mem_addr,
  output rv_pkg::xlen_t mem_wdata
);
  import rv_pkg::*;

  // Sequencer handshakes
  logic     fetch_start;
  logic     fetch_done;
  logic     mem_start;
  logic     mem_done;
  addr_t    pc;
  inst_t    fetch_inst;
  inst_t    inst;

  // Decode and execute results
  op_t      op;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  xlen_t    imm;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  xlen_t    alu_result;
  logic     branch_taken;
  addr_t    next_target;
  addr_t    mem_addr_calc;
  xlen_t    load_data;

  // Register write port
  logic     reg_we;
  reg_idx_t reg_waddr;
  xlen_t    reg_wdata;

  // Arbiter client ports
  logic     fetch_valid;
  addr_t    fetch_addr;
  logic     fetch_ready;
  logic     fetch_rvalid;
  xlen_t    fetch_rdata;
  logic     lsu_valid;
  logic     lsu_write;
  addr_t    lsu_addr;
  xlen_t    lsu_wdata;
  logic     lsu_ready;
  logic     lsu_rvalid;
  xlen_t    lsu_rdata;

  stage_sequencer u_sequencer (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .fetch_done   (fetch_done),
    .fetch_inst   (fetch_inst),
    .op           (op),
    .rd           (rd),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .next_target  (next_target),
    .mem_done     (mem_done),
    .load_data    (load_data),
    .fetch_start  (fetch_start),
    .pc           (pc),
    .inst         (inst),
    .mem_start    (mem_start),
    .reg_we       (reg_we),
    .reg_waddr    (reg_waddr),
    .reg_wdata    (reg_wdata)
  );

  instruction_fetcher u_fetcher (
    .clk          (clk),
    .reset        (reset),
    .fetch_start  (fetch_start),
    .pc           (pc),
    .fetch_ready  (fetch_ready),
    .fetch_rvalid (fetch_rvalid),
    .fetch_rdata  (fetch_rdata),
    .fetch_valid  (fetch_valid),
    .fetch_addr   (fetch_addr),
    .fetch_done   (fetch_done),
    .fetch_inst   (fetch_inst)
  );

  instruction_decoder u_decoder (
    .inst (inst),
    .op   (op),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd),
    .imm  (imm)
  );

  execute_unit u_execute (
    .op            (op),
    .pc            (pc),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .imm           (imm),
    .alu_result    (alu_result),
    .branch_taken  (branch_taken),
    .next_target   (next_target),
    .mem_addr_calc (mem_addr_calc)
  );

  register_file u_regfile (
    .clk       (clk),
    .reset     (reset),
    .stackptr  (stackptr),
    .rs1       (rs1),
    .rs2       (rs2),
    .reg_we    (reg_we),
    .reg_waddr (reg_waddr),
    .reg_wdata (reg_wdata),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  load_store_unit u_lsu (
    .clk           (clk),
    .reset         (reset),
    .mem_start     (mem_start),
    .op            (op),
    .mem_addr_calc (mem_addr_calc),
    .rs2_data      (rs2_data),
    .lsu_ready     (lsu_ready),
    .lsu_rvalid    (lsu_rvalid),
    .lsu_rdata     (lsu_rdata),
    .lsu_valid     (lsu_valid),
    .lsu_write     (lsu_write),
    .lsu_addr      (lsu_addr),
    .lsu_wdata     (lsu_wdata),
    .mem_done      (mem_done),
    .load_data     (load_data)
  );

  bus_arbiter u_arbiter (
    .clk          (clk),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_addr   (fetch_addr),
    .fetch_ready  (fetch_ready),
    .fetch_rvalid (fetch_rvalid),
    .fetch_rdata  (fetch_rdata),
    .lsu_valid    (lsu_valid),
    .lsu_write    (lsu_write),
    .lsu_addr     (lsu_addr),
    .lsu_wdata    (lsu_wdata),
    .lsu_ready    (lsu_ready),
    .lsu_rvalid   (lsu_rvalid),
    .lsu_rdata    (lsu_rdata),
    .mem_valid    (mem_valid),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_ready    (mem_ready),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata    (mem_rdata)
  );

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [63:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [3:0] {
    op_addi,
    op_add,
    op_sub,
    op_lui,
    op_ld,
    op_sd,
    op_beq,
    op_jal,
    op_illegal
  } op_t;

  typedef enum logic [2:0] {
    s_fetch,
    s_decode,
    s_execute,
    s_memory,
    s_writeback
  } seq_state_t;

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_DOUBLE  = 3'b011;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [6:0] F7_ADD     = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  localparam int unsigned INST_BYTES = 4;

endpackage

// ==== logic/stage_sequencer.sv ====
module stage_sequencer (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::addr_t    entry,
  input  logic             fetch_done,
  input  rv_pkg::inst_t    fetch_inst,
  input  rv_pkg::op_t      op,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::xlen_t    alu_result,
  input  logic             branch_taken,
  input  rv_pkg::addr_t    next_target,
  input  logic             mem_done,
  input  rv_pkg::xlen_t    load_data,
  output logic             fetch_start,
  output rv_pkg::addr_t    pc,
  output rv_pkg::inst_t    inst,
  output logic             mem_start,
  output logic             reg_we,
  output rv_pkg::reg_idx_t reg_waddr,
  output rv_pkg::xlen_t    reg_wdata
);
  import rv_pkg::*;

  seq_state_t state;
  op_t        op_q;
  reg_idx_t   rd_q;
  xlen_t      alu_q;
  addr_t      target_q;
  logic       redirect_q;
  logic       fetch_busy;
  logic       writes_rd;

  // Stores, branches and illegal encodings leave the register file alone
  assign writes_rd = op_q inside {op_addi, op_add, op_sub, op_lui, op_ld, op_jal};

  assign reg_we    = (state == s_writeback) && writes_rd;
  assign reg_waddr = rd_q;

  always_comb begin
    case (op_q)
      op_ld:   reg_wdata = load_data;
      op_jal:  reg_wdata = pc + INST_BYTES;
      default: reg_wdata = alu_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= s_fetch;
      pc          <= entry;
      fetch_start <= 1'b0;
      fetch_busy  <= 1'b0;
      mem_start   <= 1'b0;
    end else begin
      fetch_start <= 1'b0;
      mem_start   <= 1'b0;
      case (state)
        s_fetch: begin
          // One fetch request per visit
          if (!fetch_busy) begin
            fetch_start <= 1'b1;
            fetch_busy  <= 1'b1;
          end
          if (fetch_done) begin
            inst       <= fetch_inst;
            fetch_busy <= 1'b0;
            state      <= s_decode;
          end
        end
        s_decode: begin
          op_q  <= op;
          rd_q  <= rd;
          state <= s_execute;
        end
        s_execute: begin
          alu_q      <= alu_result;
          target_q   <= next_target;
          redirect_q <= branch_taken || (op_q == op_jal);
          if (op_q inside {op_ld, op_sd}) begin
            mem_start <= 1'b1;
            state     <= s_memory;
          end else begin
            state <= s_writeback;
          end
        end
        s_memory: begin
          if (mem_done) begin
            state <= s_writeback;
          end
        end
        s_writeback: begin
          pc    <= redirect_q ? target_q : pc + INST_BYTES;
          state <= s_fetch;
        end
        default: state <= s_fetch;
      endcase
    end
  end

  // Only one fetch may be in flight, and only while fetching
  assert property (@(posedge clk) disable iff (reset) fetch_done |-> state == s_fetch);

endmodule

// ==== rv_core.f ====
logic/rv_pkg.sv
logic/register_file.sv
logic/instruction_fetcher.sv
logic/instruction_decoder.sv
logic/execute_unit.sv
logic/load_store_unit.sv
logic/bus_arbiter.sv
logic/stage_sequencer.sv
logic/rv_core.sv
tests/bus_memory_model.sv
tests/rv_core_tb.sv

// ==== tests/bus_memory_model.sv ====
module bus_memory_model (
  input  logic        clk,
  input  logic        reset,
  input  logic        mem_valid,
  input  logic        mem_write,
  input  logic [63:0] mem_addr,
  input  logic [63:0] mem_wdata,
  output logic        mem_ready,
  output logic        mem_rvalid,
  output logic [63:0] mem_rdata
);

  localparam int unsigned RANDOM_SEED = 49255;
  localparam int          MEM_DWORDS  = 256;

  // Doubleword storage, indexed by address bits 10:3
  logic [63:0] mem [MEM_DWORDS];

  initial begin
    logic        in_reset;
    logic        accepted;
    logic        acc_write;
    logic [63:0] acc_addr;
    logic [63:0] acc_wdata;
    logic        read_pending;
    logic [63:0] read_addr;
    int unsigned ready_wait;
    int unsigned resp_wait;

    void'($urandom(RANDOM_SEED));
    mem_ready    = 1'b0;
    mem_rvalid   = 1'b0;
    mem_rdata    = '0;
    read_pending = 1'b0;
    read_addr    = '0;
    ready_wait   = $urandom % 4;
    resp_wait    = 0;
    forever begin
      // Request as the DUT presented it at this edge
      @(posedge clk);
      in_reset  = reset;
      accepted  = mem_valid && mem_ready && !reset;
      acc_write = mem_write;
      acc_addr  = mem_addr;
      acc_wdata = mem_wdata;
      #1;
      mem_rvalid = 1'b0;
      if (in_reset) begin
        mem_ready    = 1'b0;
        read_pending = 1'b0;
      end else begin
        if (accepted) begin
          mem_ready  = 1'b0;
          ready_wait = $urandom % 4;
          if (acc_write) begin
            mem[acc_addr[10:3]] = acc_wdata;
          end else begin
            read_pending = 1'b1;
            read_addr    = acc_addr;
            resp_wait    = $urandom % 4;
          end
        end else if (mem_valid && !mem_ready) begin
          if (ready_wait == 0) begin
            mem_ready = 1'b1;
          end else begin
            ready_wait--;
          end
        end
        // Earliest response is seen one edge after acceptance
        if (read_pending) begin
          if (resp_wait == 0) begin
            mem_rvalid   = 1'b1;
            mem_rdata    = mem[read_addr[10:3]];
            read_pending = 1'b0;
          end else begin
            resp_wait--;
          end
        end
      end
    end
  end

endmodule

// ==== tests/rv_core_tb.sv ====
module rv_core_tb;

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 4;
  localparam int          NUM_INSTS    = 24;
  localparam int          NUM_STORES   = 8;
  localparam int          MEM_DWORDS   = 256;
  localparam int          TAIL_CYCLES  = 60;
  localparam logic [63:0] ENTRY        = 64'h104;
  localparam logic [63:0] STACKPTR     = 64'h700;
  localparam logic [63:0] DATA_ADDR    = 64'h400;
  localparam logic [63:0] DATA_WORD    = 64'h1234_5678_9abc_def0;

  // RV64I major opcodes
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] LOAD   = 7'b0000011;
  localparam logic [6:0] STORE  = 7'b0100011;
  localparam logic [6:0] BRANCH = 7'b1100011;
  localparam logic [6:0] JAL    = 7'b1101111;

  logic        clk;
  logic        reset;
  logic [63:0] entry;
  logic [63:0] stackptr;
  logic        mem_ready;
  logic        mem_rvalid;
  logic [63:0] mem_rdata;
  logic        mem_valid;
  logic        mem_write;
  logic [63:0] mem_addr;
  logic [63:0] mem_wdata;

  logic [31:0] program_words [NUM_INSTS];
  logic [63:0] store_addr [NUM_STORES];
  logic [63:0] store_data [NUM_STORES];

  rv_core DUT (
    .clk        (clk),
    .reset      (reset),
    .entry      (entry),
    .stackptr   (stackptr),
    .mem_ready  (mem_ready),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .mem_valid  (mem_valid),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata)
  );

  bus_memory_model mem_model (
    .clk        (clk),
    .reset      (reset),
    .mem_valid  (mem_valid),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ready  (mem_ready),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata)
  );

  function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                         input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                         input int rd);
    return {f7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OP_REG};
  endfunction

  function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], STORE};
  endfunction

  function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], LUI};
  endfunction

  function automatic logic [31:0] j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], JAL};
  endfunction

  task automatic build_tables();
    // Program from ENTRY, one word per instruction
    program_words = '{
      i_type(100, 0, 3'b000, 5, OP_IMM),   // addi x5, x0, 100
      i_type(-7, 0, 3'b000, 6, OP_IMM),    // addi x6, x0, -7
      r_type(7'h00, 6, 5, 7),              // add  x7, x5, x6
      s_type(0, 7, 2),                     // sd   x7, 0(x2)
      r_type(7'h20, 6, 5, 8),              // sub  x8, x5, x6
      s_type(8, 8, 2),                     // sd   x8, 8(x2)
      u_type('h12345, 9),                  // lui  x9, 0x12345
      s_type(-8, 9, 2),                    // sd   x9, -8(x2)
      u_type('h80000, 10),                 // lui  x10, 0x80000
      s_type(16, 10, 2),                   // sd   x10, 16(x2)
      i_type('h400, 0, 3'b000, 11, OP_IMM),
      i_type(0, 11, 3'b011, 12, LOAD),     // ld   x12, 0(x11)
      r_type(7'h00, 5, 12, 13),            // add  x13, x12, x5
      s_type(24, 13, 2),
      i_type(1, 5, 3'b000, 0, OP_IMM),     // addi x0, x5, 1
      s_type(32, 0, 2),
      b_type(8, 5, 5),                     // beq  x5, x5 taken
      s_type(40, 5, 2),
      b_type(8, 6, 5),                     // beq  x5, x6 falls through
      s_type(48, 6, 2),
      j_type(8, 14),                       // jal  x14, +8
      s_type(56, 5, 2),
      s_type(64, 14, 2),
      j_type(0, 0)                         // Park here
    };
    store_addr = '{STACKPTR, STACKPTR + 8, STACKPTR - 8, STACKPTR + 16,
                   STACKPTR + 24, STACKPTR + 32, STACKPTR + 48, STACKPTR + 64};
    store_data = '{64'd93, 64'd107, 64'h1234_5000, 64'hffff_ffff_8000_0000,
                   DATA_WORD + 64'd100, 64'd0, 64'hffff_ffff_ffff_fff9, ENTRY + 64'd84};
  endtask

  task automatic put_inst(input logic [63:0] addr, input logic [31:0] word);
    if (addr[2]) begin
      mem_model.mem[addr[10:3]][63:32] = word;
    end else begin
      mem_model.mem[addr[10:3]][31:0] = word;
    end
  endtask

  task automatic load_memory();
    logic [63:0] byte_addr;
    // Fill derived from the full byte address
    for (int i = 0; i < MEM_DWORDS; i++) begin
      byte_addr = 64'(i) << 3;
      mem_model.mem[i] = {~byte_addr[31:0], byte_addr[31:0]};
    end
    for (int k = 0; k < NUM_INSTS; k++) begin
      put_inst(ENTRY + 64'(4 * k), program_words[k]);
    end
    mem_model.mem[DATA_ADDR[10:3]] = DATA_WORD;
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Stopping at the first failure");
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_STORES * 200 * CLK_PERIOD);
    abort_run("Timeout: the core did not produce all expected stores in time");
  end

  initial begin
    reset    = 1'b1;
    entry    = ENTRY;
    stackptr = STACKPTR;
    build_tables();
    load_memory();
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      assert (mem_valid === 1'b0)
        else abort_run($sformatf("** Error at %0t: mem_valid high during reset", $time));
    end
    reset = 1'b0;

    // First bus request reads the doubleword holding the entry point
    do @(posedge clk); while (mem_valid !== 1'b1);
    assert (!mem_write && mem_addr == (ENTRY & ~64'h7))
      else abort_run($sformatf("** Error at %0t: first request write=%b addr=%h, expected read %h",
                               $time, mem_write, mem_addr, ENTRY & ~64'h7));

    for (int row = 0; row < NUM_STORES; row++) begin
      do @(posedge clk); while (!(mem_valid && mem_ready && mem_write));
      assert (mem_addr == store_addr[row])
        else abort_run($sformatf("** Error at %0t: store %0d address %h, expected %h",
                                 $time, row, mem_addr, store_addr[row]));
      assert (mem_wdata == store_data[row])
        else abort_run($sformatf("** Error at %0t: store %0d data %h, expected %h",
                                 $time, row, mem_wdata, store_data[row]));
    end

    // Program is parked in a self loop, so the bus must see no more writes
    repeat (TAIL_CYCLES) begin
      @(posedge clk);
      assert (!(mem_valid && mem_ready && mem_write))
        else abort_run($sformatf("** Error at %0t: extra store to %h data %h",
                                 $time, mem_addr, mem_wdata));
    end
    $display("Regression passed");
    $finish;
  end

endmodule
